// ==== logic/mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

    localparam int regAddrW = 5;

    // instruction fields
    localparam int opW = 6;
    localparam int opLsb = 26;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;
    localparam int functW = 6;   // funct sits at bit 0
    localparam int immW = 16;
    localparam int targetW = 26;

    // primary opcodes of the supported subset
    typedef enum logic [opW-1:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    // funct codes under opSpecial
    typedef enum logic [functW-1:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnXor  = 6'h26,
        fnSlt  = 6'h2a
    } functT;

endpackage

`default_nettype wire

// ==== logic/pipeCtrlPkg.sv ====
`default_nettype none

package pipeCtrlPkg;

    localparam int dataW = 32;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluLui
    } aluOpT;

    // execute operand source
    typedef enum logic [1:0] {
        fwdReg,   // value read in decode
        fwdM,     // non-load result in M
        fwdW
    } fwdSelT;

    // which field names the destination register
    typedef enum logic [1:0] {
        dstRd,
        dstRt,
        dstNone
    } regDstT;

endpackage

`default_nettype wire

// ==== logic/mainDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module mainDecoder import mipsIsaPkg::*, pipeCtrlPkg::*; (
    input  wire [31:0] instrD,
    output aluOpT      aluOpD,
    output regDstT     regDstD,
    output logic       aluImmSelD,
    output logic       signExtD,
    output logic       memReadEnD,
    output logic       memWriteEnD,
    output logic       regWriteEnD,
    output logic       branchD,
    output logic       branchNeD,
    output logic       jumpD
);

    opcodeT op;
    functT fn;

    assign op = opcodeT'(instrD[opLsb +: opW]);
    assign fn = functT'(instrD[functW-1:0]);

    always_comb begin
        // defaults are a nop
        aluOpD = aluAdd;
        regDstD = dstNone;
        aluImmSelD = 1'b0;
        signExtD = 1'b0;
        memReadEnD = 1'b0;
        memWriteEnD = 1'b0;
        regWriteEnD = 1'b0;
        branchD = 1'b0;
        branchNeD = 1'b0;
        jumpD = 1'b0;
        case (op)
            opSpecial: begin
                regDstD = dstRd;
                regWriteEnD = 1'b1;
                case (fn)
                    fnAddu: aluOpD = aluAdd;
                    fnSubu: aluOpD = aluSub;
                    fnAnd:  aluOpD = aluAnd;
                    fnOr:   aluOpD = aluOr;
                    fnXor:  aluOpD = aluXor;
                    fnSlt:  aluOpD = aluSlt;
                    default: begin
                        regDstD = dstNone;   // sll nop lands here too
                        regWriteEnD = 1'b0;
                    end
                endcase
            end
            opAddiu, opLw: begin
                regDstD = dstRt;
                aluImmSelD = 1'b1;
                signExtD = 1'b1;
                regWriteEnD = 1'b1;
                memReadEnD = (op == opLw);
            end
            opAndi, opOri, opLui: begin
                regDstD = dstRt;
                aluImmSelD = 1'b1;   // zero extended
                regWriteEnD = 1'b1;
                aluOpD = (op == opAndi) ? aluAnd : (op == opOri) ? aluOr : aluLui;
            end
            opSw: begin
                aluImmSelD = 1'b1;
                signExtD = 1'b1;
                memWriteEnD = 1'b1;
            end
            opBeq, opBne: begin
                aluOpD = aluSub;
                signExtD = 1'b1;     // offset for the target adder
                branchD = 1'b1;
                branchNeD = (op == opBne);
            end
            opJ: jumpD = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile #(
    parameter int addrW = 5,
    parameter int dataW = 32
) (
    input  wire             clk,
    input  wire             we,
    input  wire [addrW-1:0] ra1,
    input  wire [addrW-1:0] ra2,
    input  wire [addrW-1:0] wa,
    input  wire [dataW-1:0] wd,
    output logic [dataW-1:0] rd1,
    output logic [dataW-1:0] rd2
);

    logic [dataW-1:0] regs [1:2**addrW-1];   // r0 has no storage

    always_ff @(posedge clk) begin
        if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // write in flight is visible to decode in the same cycle
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu import pipeCtrlPkg::*; (
    input  wire [dataW-1:0] srcA,
    input  wire [dataW-1:0] srcB,
    input  wire aluOpT      aluOp,
    input  wire             branchNe,
    output logic [dataW-1:0] result,
    output logic            actualTake
);

    logic [dataW-1:0] diff;
    logic lessThan;
    logic isZero;

    assign diff = srcA - srcB;
    assign isZero = (diff == '0);

    // signed compare, sign bits decide when they differ
    assign lessThan = (srcA[dataW-1] != srcB[dataW-1]) ? srcA[dataW-1] : diff[dataW-1];

    always_comb begin
        case (aluOp)
            aluAdd: result = srcA + srcB;
            aluSub: result = diff;
            aluAnd: result = srcA & srcB;
            aluOr:  result = srcA | srcB;
            aluXor: result = srcA ^ srcB;
            aluSlt: result = {{(dataW-1){1'b0}}, lessThan};
            aluLui: result = {srcB[dataW/2-1:0], {(dataW/2){1'b0}}};
            default: result = '0;
        endcase
    end

    // beq / bne condition on the forwarded operands
    assign actualTake = branchNe ? ~isZero : isZero;

endmodule

`default_nettype wire

// ==== logic/hazardUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import mipsIsaPkg::*, pipeCtrlPkg::*; (
    input  wire                iCacheStall,
    input  wire                dCacheStall,
    input  wire                memReadEnE,
    input  wire [regAddrW-1:0] rsD,
    input  wire [regAddrW-1:0] rtD,
    input  wire [regAddrW-1:0] rsE,
    input  wire [regAddrW-1:0] rtE,
    input  wire [regAddrW-1:0] regWriteE,
    input  wire                regWriteEnM,
    input  wire [regAddrW-1:0] regWriteM,
    input  wire                regWriteEnW,
    input  wire [regAddrW-1:0] regWriteW,
    input  wire                takeE,
    output logic               stallF,
    output logic               stallD,
    output logic               stallE,
    output logic               stallM,
    output logic               flushD,
    output logic               flushE,
    output fwdSelT             forwardAE,
    output fwdSelT             forwardBE
);

    logic cacheStall;
    logic loadUse;

    // M has priority since it is the younger producer
    function automatic fwdSelT pickSource(input logic [regAddrW-1:0] src);
        if (regWriteEnM && regWriteM != '0 && regWriteM == src) begin
            return fwdM;
        end
        if (regWriteEnW && regWriteW != '0 && regWriteW == src) begin
            return fwdW;
        end
        return fwdReg;
    endfunction

    assign cacheStall = iCacheStall | dCacheStall;

    // lw in E whose result a D source needs
    assign loadUse = memReadEnE && regWriteE != '0 && (rtE == rsD || rtE == rtD);

    assign stallF = cacheStall | loadUse;
    assign stallD = cacheStall | loadUse;
    assign stallE = cacheStall;
    assign stallM = cacheStall;   // W follows M

    assign flushD = takeE & ~cacheStall;    // drops the word after the delay slot
    assign flushE = loadUse & ~cacheStall;

    always_comb begin
        forwardAE = pickSource(rsE);
        forwardBE = pickSource(rtE);
    end

endmodule

`default_nettype wire

// ==== logic/mipsDatapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module mipsDatapath import mipsIsaPkg::*, pipeCtrlPkg::*; #(
    parameter logic [dataW-1:0] resetVector = 32'hBFC00000
) (
    input  wire              clk,
    input  wire              rstN,
    output logic [dataW-1:0] pcF,
    output logic             instEnF,
    input  wire [31:0]       instrF,
    input  wire              iCacheStall,
    output logic             stallF,
    output logic             memEnM,
    output logic [dataW-1:0] memAddrM,
    output logic [3:0]       memWenM,
    output logic [dataW-1:0] memWdataM,
    input  wire [dataW-1:0]  memRdataM,
    input  wire              dCacheStall,
    output logic [dataW-1:0] debugWbPc,
    output logic [3:0]       debugWbRfWen,
    output logic [regAddrW-1:0] debugWbRfWnum,
    output logic [dataW-1:0] debugWbRfWdata
);

    logic fetchOn;
    logic [dataW-1:0] pcNextF;

    logic validD;
    logic [dataW-1:0] pcD, instrD, pcPlus4D, rd1D, rd2D, immD, jumpTargetD;
    logic [regAddrW-1:0] rsD, rtD, rdD;
    aluOpT aluOpD;
    regDstT regDstD;
    logic aluImmSelD, signExtD, memReadEnD, memWriteEnD, regWriteEnD;
    logic branchD, branchNeD, jumpD;

    logic validE;
    logic [dataW-1:0] pcE, rd1E, rd2E, immE;
    logic [regAddrW-1:0] rsE, rtE, rdE, regWriteE;
    aluOpT aluOpE;
    regDstT regDstE;
    logic aluImmSelE, memReadEnE, memWriteEnE, regWriteEnE, branchE, branchNeE;
    logic [dataW-1:0] srcAE, fwdBE, srcBE, aluOutE, branchTargetE;
    logic actualTakeE, takeE;
    fwdSelT forwardAE, forwardBE;

    logic validM;
    logic [dataW-1:0] pcM, aluOutM, wdataM, resultM;
    logic [regAddrW-1:0] regWriteM;
    logic regWriteEnM, memReadEnM, memWriteEnM, rfWeM;

    logic validW;
    logic [dataW-1:0] resultW;
    logic [regAddrW-1:0] regWriteW;
    logic regWriteEnW;

    logic stallD, stallE, stallM, flushD, flushE;

    function automatic logic [dataW-1:0] fwdMux(input fwdSelT sel, input logic [dataW-1:0] regVal);
        case (sel)
            fwdM: return aluOutM;
            fwdW: return resultW;
            default: return regVal;
        endcase
    endfunction

    // branch in E wins over a jump sitting in its delay slot
    assign pcNextF = takeE ? branchTargetE : (validD && jumpD) ? jumpTargetD : pcF + 32'd4;
    assign instEnF = fetchOn & ~flushD;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcF <= resetVector;
            fetchOn <= 1'b0;
        end else begin
            fetchOn <= 1'b1;
            if (fetchOn && !stallF) begin
                pcF <= pcNextF;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) validD <= 1'b0;
        else if (!stallD) validD <= instEnF;
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pcF;
            instrD <= instrF;
        end
    end

    assign rsD = instrD[rsLsb +: regAddrW];
    assign rtD = instrD[rtLsb +: regAddrW];
    assign rdD = instrD[rdLsb +: regAddrW];
    assign pcPlus4D = pcD + 32'd4;
    assign immD = {{(dataW-immW){signExtD & instrD[immW-1]}}, instrD[immW-1:0]};
    assign jumpTargetD = {pcPlus4D[31:28], instrD[targetW-1:0], 2'b00};

    mainDecoder u_mainDecoder (
        .instrD(instrD), .aluOpD(aluOpD), .regDstD(regDstD),
        .aluImmSelD(aluImmSelD), .signExtD(signExtD),
        .memReadEnD(memReadEnD), .memWriteEnD(memWriteEnD), .regWriteEnD(regWriteEnD),
        .branchD(branchD), .branchNeD(branchNeD), .jumpD(jumpD)
    );

    regFile #(.addrW(regAddrW), .dataW(dataW)) u_regFile (
        .clk(clk), .we(rfWeM), .ra1(rsD), .ra2(rtD), .wa(regWriteM), .wd(resultM),
        .rd1(rd1D), .rd2(rd2D)
    );

    always_ff @(posedge clk) begin
        if (!rstN) validE <= 1'b0;
        else if (!stallE) validE <= validD & ~flushE;   // load-use bubble
    end

    always_ff @(posedge clk) begin
        if (!stallE) begin
            pcE <= pcD;
            rd1E <= rd1D;
            rd2E <= rd2D;
            immE <= immD;
            rsE <= rsD;
            rtE <= rtD;
            rdE <= rdD;
            aluOpE <= aluOpD;
            regDstE <= regDstD;
            aluImmSelE <= aluImmSelD;
            memReadEnE <= memReadEnD;
            memWriteEnE <= memWriteEnD;
            regWriteEnE <= regWriteEnD;
            branchE <= branchD;
            branchNeE <= branchNeD;
        end
    end

    always_comb begin
        srcAE = fwdMux(forwardAE, rd1E);
        fwdBE = fwdMux(forwardBE, rd2E);
    end

    assign srcBE = aluImmSelE ? immE : fwdBE;
    assign branchTargetE = pcE + 32'd4 + {immE[29:0], 2'b00};
    assign takeE = validE & branchE & actualTakeE;

    always_comb begin
        case (regDstE)
            dstRd: regWriteE = rdE;
            dstRt: regWriteE = rtE;
            default: regWriteE = '0;
        endcase
    end

    alu u_alu (
        .srcA(srcAE), .srcB(srcBE), .aluOp(aluOpE), .branchNe(branchNeE),
        .result(aluOutE), .actualTake(actualTakeE)
    );

    hazardUnit u_hazardUnit (
        .iCacheStall(iCacheStall), .dCacheStall(dCacheStall),
        .memReadEnE(validE & memReadEnE),
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE), .regWriteE(regWriteE),
        .regWriteEnM(validM & regWriteEnM), .regWriteM(regWriteM),
        .regWriteEnW(validW & regWriteEnW), .regWriteW(regWriteW),
        .takeE(takeE),
        .stallF(stallF), .stallD(stallD), .stallE(stallE), .stallM(stallM),
        .flushD(flushD), .flushE(flushE),
        .forwardAE(forwardAE), .forwardBE(forwardBE)
    );

    always_ff @(posedge clk) begin
        if (!rstN) validM <= 1'b0;
        else if (!stallM) validM <= validE;
    end

    always_ff @(posedge clk) begin
        if (!stallM) begin
            pcM <= pcE;
            aluOutM <= aluOutE;
            wdataM <= fwdBE;        // store data after forwarding
            regWriteM <= regWriteE;
            regWriteEnM <= regWriteEnE;
            memReadEnM <= memReadEnE;
            memWriteEnM <= memWriteEnE;
        end
    end

    // word access only
    assign memEnM = validM & (memReadEnM | memWriteEnM);
    assign memAddrM = aluOutM;
    assign memWenM = {4{validM & memWriteEnM}};
    assign memWdataM = wdataM;

    assign resultM = memReadEnM ? memRdataM : aluOutM;
    assign rfWeM = validM & regWriteEnM & ~stallM;   // no write while frozen

    assign debugWbPc = pcM;
    assign debugWbRfWen = {4{rfWeM}};
    assign debugWbRfWnum = regWriteM;
    assign debugWbRfWdata = resultM;

    // W only feeds the forwarding muxes
    always_ff @(posedge clk) begin
        if (!rstN) validW <= 1'b0;
        else if (!stallM) validW <= validM;
    end

    always_ff @(posedge clk) begin
        if (!stallM) begin
            resultW <= resultM;
            regWriteW <= regWriteM;
            regWriteEnW <= regWriteEnM;
        end
    end

endmodule

`default_nettype wire

// ==== test/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// in-order reference run inside the testbench module

logic [31:0] modelRegs [32];
logic [31:0] modelMem [256];

// predicted fetches, writebacks and stores in program order
logic [31:0] expFetchPc [$];
logic [31:0] expWbPc [$];
logic [4:0]  expWbNum [$];
logic [31:0] expWbData [$];
logic [31:0] expStAddr [$];
logic [31:0] expStData [$];

// every bit of the word index feeds the pattern
function automatic logic [31:0] fillWord(input int unsigned idx);
    return (32'(idx) * 32'h9e37_79b1) ^ 32'h5a5a_0000 ^ 32'(idx);
endfunction

task automatic recordWb(input logic [31:0] pc, input logic [4:0] num, input logic [31:0] data);
    expWbPc.push_back(pc);
    expWbNum.push_back(num);
    expWbData.push_back(data);
    if (num != 5'd0) begin
        modelRegs[num] = data;
    end
endtask

task automatic runModel(input logic [31:0] startPc);
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] cur;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immS;
    logic [31:0] immZ;
    logic [31:0] addr;
    logic [31:0] target;
    logic [5:0] op;
    logic [5:0] fn;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic taken;
    logic done;
    int steps;
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = 32'h0;
    end
    for (int i = 0; i < 256; i++) begin
        modelMem[i] = fillWord(i);
    end
    pc = startPc;
    nextPc = startPc + 32'd4;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
        cur = pc;
        pc = nextPc;
        nextPc = nextPc + 32'd4;   // delay slot runs before any redirect
        expFetchPc.push_back(cur);
        instr = imem[cur[9:2]];
        op = instr[31:26];
        fn = instr[5:0];
        rs = instr[25:21];
        rt = instr[20:16];
        rd = instr[15:11];
        a = modelRegs[rs];
        b = modelRegs[rt];
        immS = {{16{instr[15]}}, instr[15:0]};
        immZ = {16'h0, instr[15:0]};
        taken = 1'b0;
        case (op)
            6'h00: begin
                case (fn)
                    6'h21: recordWb(cur, rd, a + b);
                    6'h23: recordWb(cur, rd, a - b);
                    6'h24: recordWb(cur, rd, a & b);
                    6'h25: recordWb(cur, rd, a | b);
                    6'h26: recordWb(cur, rd, a ^ b);
                    6'h2a: recordWb(cur, rd, {31'b0, $signed(a) < $signed(b)});
                    default: ;
                endcase
            end
            6'h09: recordWb(cur, rt, a + immS);
            6'h0c: recordWb(cur, rt, a & immZ);
            6'h0d: recordWb(cur, rt, a | immZ);
            6'h0f: recordWb(cur, rt, {instr[15:0], 16'h0});
            6'h23: begin
                addr = a + immS;
                recordWb(cur, rt, modelMem[addr[9:2]]);
            end
            6'h2b: begin
                addr = a + immS;
                modelMem[addr[9:2]] = b;
                expStAddr.push_back(addr);
                expStData.push_back(b);
            end
            6'h04: taken = (a == b);
            6'h05: taken = (a != b);
            6'h02: begin
                target = cur + 32'd4;
                nextPc = {target[31:28], instr[25:0], 2'b00};
            end
            default: ;
        endcase
        if (taken) begin
            target = cur + 32'd4 + {immS[29:0], 2'b00};
            nextPc = target;
            if (target == cur) begin
                done = 1'b1;   // program parks on a branch to itself
            end
        end
        steps++;
    end
endtask

`endif

// ==== test/mipsDatapathTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mipsDatapathTb;

    logic clk;
    logic rstN;
    logic iCacheStall;
    logic dCacheStall;
    logic [31:0] instrF;
    logic [31:0] memRdataM;
    logic [31:0] pcF;
    logic instEnF;
    logic stallF;
    logic memEnM;
    logic [31:0] memAddrM;
    logic [3:0] memWenM;
    logic [31:0] memWdataM;
    logic [31:0] debugWbPc;
    logic [3:0] debugWbRfWen;
    logic [4:0] debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    int errorCount;
    int wbCount;
    int storeCount;
    int expectedWbs;
    int expectedStores;
    int sinceReset;
    int waitCycles;

    `include "isaModel.svh"

    always #4 clk = ~clk;

    // both memories answer in the same cycle
    assign instrF = imem[pcF[9:2]];
    assign memRdataM = dmem[memAddrM[9:2]];

    mipsDatapath #(.resetVector(32'h0)) u_mipsDatapath (
        .clk(clk), .rstN(rstN),
        .pcF(pcF), .instEnF(instEnF), .instrF(instrF),
        .iCacheStall(iCacheStall), .stallF(stallF),
        .memEnM(memEnM), .memAddrM(memAddrM), .memWenM(memWenM),
        .memWdataM(memWdataM), .memRdataM(memRdataM), .dCacheStall(dCacheStall),
        .debugWbPc(debugWbPc), .debugWbRfWen(debugWbRfWen),
        .debugWbRfWnum(debugWbRfWnum), .debugWbRfWdata(debugWbRfWdata)
    );

    always @(posedge clk) begin
        if (memEnM && memWenM != 4'h0 && !dCacheStall) begin
            dmem[memAddrM[9:2]] <= memWdataM;
        end
    end

    // roughly one stall cycle in five on each side
    always @(posedge clk) begin
        if (!rstN) begin
            iCacheStall <= 1'b0;
            dCacheStall <= 1'b0;
        end else begin
            iCacheStall <= ($urandom % 5) == 0;
            dCacheStall <= ($urandom % 5) == 0;
        end
    end

    always @(posedge clk) begin
        if (!rstN) sinceReset <= 0;
        else if (sinceReset < 100) sinceReset <= sinceReset + 1;
    end

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (expVal == actVal) else begin
            $display("ERROR %s expected %h actual %h", name, expVal, actVal);
            errorCount++;
        end
    endtask

    firstFetch: assert property (@(posedge clk) $rose(rstN) |-> pcF == 32'h0) else begin
        $display("ERROR firstFetch expected %h actual %h", 32'h0, pcF);
        errorCount++;
    end

    quietStart: assert property (@(posedge clk)
        (rstN && sinceReset <= 3) |-> (!memEnM && debugWbRfWen == 4'h0)) else begin
        $display("memory or writeback active before the first instruction reached M");
        errorCount++;
    end

    // accepted fetches follow the in-order pc stream
    always @(posedge clk) begin
        if (rstN && instEnF && !stallF && expFetchPc.size() != 0) begin
            checkValue("fetch pc", expFetchPc.pop_front(), pcF);
        end
    end

    always @(posedge clk) begin
        if (rstN && debugWbRfWen != 4'h0) begin
            checkValue("writeback enable", 32'hf, 32'(debugWbRfWen));
            if (expWbPc.size() == 0) begin
                $display("unexpected writeback from pc %h to r%0d", debugWbPc, debugWbRfWnum);
                errorCount++;
            end else begin
                checkValue("writeback pc", expWbPc.pop_front(), debugWbPc);
                checkValue("writeback reg", 32'(expWbNum.pop_front()), 32'(debugWbRfWnum));
                checkValue("writeback data", expWbData.pop_front(), debugWbRfWdata);
            end
            wbCount++;
        end
    end

    // M advances only when neither cache stalls
    always @(posedge clk) begin
        if (rstN && memEnM && memWenM != 4'h0 && !iCacheStall && !dCacheStall) begin
            checkValue("store strobes", 32'hf, 32'(memWenM));
            if (expStAddr.size() == 0) begin
                $display("unexpected store of %h to %h", memWdataM, memAddrM);
                errorCount++;
            end else begin
                checkValue("store addr", expStAddr.pop_front(), memAddrM);
                checkValue("store data", expStData.pop_front(), memWdataM);
            end
            storeCount++;
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        errorCount = 0;
        wbCount = 0;
        storeCount = 0;
        sinceReset = 0;
        void'($urandom(32'h4cee_785c));
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
            dmem[i] = fillWord(i);
        end
        $readmemh("test/program.hex", imem);
        runModel(32'h0);
        expectedWbs = expWbPc.size();
        expectedStores = expStAddr.size();

        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        waitCycles = 0;
        while ((expWbPc.size() != 0 || expStAddr.size() != 0) && waitCycles < 2000) begin
            @(posedge clk);
            waitCycles++;
        end
        if (expWbPc.size() != 0 || expStAddr.size() != 0) begin
            $display("timeout with %0d writebacks and %0d stores still outstanding",
                     expWbPc.size(), expStAddr.size());
            errorCount++;
        end

        // idle loop must stay silent
        waitCycles = 0;
        while (waitCycles < 40) begin
            @(posedge clk);
            waitCycles++;
        end

        $display("errors=%0d writebacks=%0d/%0d stores=%0d/%0d",
                 errorCount, wbCount, expectedWbs, storeCount, expectedStores);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/program.hex ====
// one instruction word per line, from word address 0 upward
// ends in a branch to itself with a nop in its delay slot
24010005
2422FFFD
00221821
00612023
3C058001
34A5F0F0
30A6FF00
00A63826
00E1402A
00A74824
01035025
AC050010
8C0B0008
01616021
8C0D0010
AC0D0014
10220005
240E0001
14220003
240F0002
24100003
24100004
10630003
26310010
24120005
24120006
0800001E
24130007
24140008
24140009
14000001
AE2F0000
1000FFFF
00000000

// ==== mipsDatapath.f ====
+incdir+test
logic/mipsIsaPkg.sv
logic/pipeCtrlPkg.sv
logic/mainDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/hazardUnit.sv
logic/mipsDatapath.sv
test/mipsDatapathTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run with Verilator, result decided from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f mipsDatapath.f --top-module mipsDatapathTb \
    -o simv > build.log 2>&1 && ./obj_dir/simv > sim.log 2>&1 || { echo "build or run error"; exit 1; }
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
